// ==== hw/rv_isa_pkg.sv ====
// RV32I operation encodings used by the execute stage.
// Values are internal to this stage and do not match the ISA funct fields.
package rv_isa_pkg;

	// alu operations with lui as pass_b
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_e;

	// branch conditions where jal covers jalr too
	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_JAL  = 3'd1,
		BR_BEQ  = 3'd2,
		BR_BNE  = 3'd3,
		BR_BLT  = 3'd4,
		BR_BGE  = 3'd5,
		BR_BLTU = 3'd6,
		BR_BGEU = 3'd7
	} branch_e;

	typedef enum logic [2:0] {
		LD_NONE = 3'd0,
		LD_LB   = 3'd1,
		LD_LH   = 3'd2,
		LD_LW   = 3'd3,
		LD_LBU  = 3'd4,
		LD_LHU  = 3'd5
	} load_e;

	typedef enum logic [1:0] {
		ST_NONE = 2'd0,
		ST_SB   = 2'd1,
		ST_SH   = 2'd2,
		ST_SW   = 2'd3
	} store_e;

endpackage

// ==== hw/ex_cfg_pkg.sv ====
// Fixed RV32I widths for the execute stage.
package ex_cfg_pkg;

	// data and address width
	localparam int XLEN = 32;

	// destination register index
	localparam int REG_ADDR_W = 5;

	// one strobe per byte lane
	localparam int STRB_W = XLEN / 8;

endpackage

// ==== hw/ex_alu.sv ====
// Combinational RV32I integer ALU.
// Shift amounts use the low five bits of b_i only.
// Unknown opcodes give zero; legality is checked at the stage input.
`timescale 1ns/1ps

module ex_alu
	import rv_isa_pkg::*;
	import ex_cfg_pkg::*;
(
	input  alu_op_e          op_i,
	input  logic [XLEN-1:0]  a_i,
	input  logic [XLEN-1:0]  b_i,
	output logic [XLEN-1:0]  result_o
);

	logic [4:0]      shamt;
	logic            lt_signed;
	logic            lt_unsigned;
	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] diff;

	assign shamt       = b_i[4:0];
	assign lt_signed   = $signed(a_i) < $signed(b_i);
	assign lt_unsigned = a_i < b_i;
	assign sum         = a_i + b_i;
	assign diff        = a_i - b_i;

	always_comb begin
		case (op_i)
			ALU_ADD: begin
				result_o = sum;
			end
			ALU_SUB: begin
				result_o = diff;
			end
			ALU_SLL: begin
				result_o = a_i << shamt;
			end
			ALU_SLT: begin
				result_o = {{(XLEN-1){1'b0}}, lt_signed};
			end
			ALU_SLTU: begin
				result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
			end
			ALU_XOR: begin
				result_o = a_i ^ b_i;
			end
			ALU_SRL: begin
				result_o = a_i >> shamt;
			end
			ALU_SRA: begin
				// arithmetic shift keeps the sign
				result_o = $signed(a_i) >>> shamt;
			end
			ALU_OR: begin
				result_o = a_i | b_i;
			end
			ALU_AND: begin
				result_o = a_i & b_i;
			end
			ALU_PASS_B: begin
				result_o = b_i;
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

// ==== hw/ex_branch_unit.sv ====
// Branch decision and jump target for RV32I.
// Target is jmp_a_i + jmp_b_i with bit 0 cleared, as jalr requires.
`timescale 1ns/1ps

module ex_branch_unit
	import rv_isa_pkg::*;
	import ex_cfg_pkg::*;
(
	input  branch_e          branch_i,
	input  logic [XLEN-1:0]  rs1_i,
	input  logic [XLEN-1:0]  rs2_i,
	input  logic [XLEN-1:0]  jmp_a_i,
	input  logic [XLEN-1:0]  jmp_b_i,
	output logic             take_o,
	output logic [XLEN-1:0]  target_o
);

	logic            eq;
	logic            lt_s;
	logic            lt_u;
	logic [XLEN-1:0] sum;

	assign eq   = rs1_i == rs2_i;
	assign lt_s = $signed(rs1_i) < $signed(rs2_i);
	assign lt_u = rs1_i < rs2_i;
	assign sum  = jmp_a_i + jmp_b_i;

	assign target_o = {sum[XLEN-1:1], 1'b0};

	always_comb begin
		case (branch_i)
			BR_JAL:  take_o = 1'b1;
			BR_BEQ:  take_o = eq;
			BR_BNE:  take_o = !eq;
			BR_BLT:  take_o = lt_s;
			BR_BGE:  take_o = !lt_s;
			BR_BLTU: take_o = lt_u;
			BR_BGEU: take_o = !lt_u;
			default: take_o = 1'b0;
		endcase
	end

endmodule

// ==== hw/ex_store_unit.sv ====
// Memory request, store data lanes and byte strobes.
// Little endian; misaligned halfword and word stores are not split.
// Loads raise a request with zero strobes.
`timescale 1ns/1ps

module ex_store_unit
	import rv_isa_pkg::*;
	import ex_cfg_pkg::*;
(
	input  load_e              load_i,
	input  store_e             store_i,
	input  logic [XLEN-1:0]    addr_i,
	input  logic [XLEN-1:0]    rs2_i,
	output logic               req_o,
	output logic               we_o,
	output logic [XLEN-1:0]    wdata_o,
	output logic [STRB_W-1:0]  wstrb_o
);

	logic [1:0] offset;

	assign offset = addr_i[1:0];

	assign req_o = (load_i != LD_NONE) || (store_i != ST_NONE);
	assign we_o  = store_i != ST_NONE;

	// data replicated into every lane and strobes pick the live one
	always_comb begin
		case (store_i)
			ST_SB: begin
				wdata_o = {4{rs2_i[7:0]}};
				wstrb_o = 4'b0001 << offset;
			end
			ST_SH: begin
				wdata_o = {2{rs2_i[15:0]}};
				wstrb_o = offset[1] ? 4'b1100 : 4'b0011;
			end
			ST_SW: begin
				wdata_o = rs2_i;
				wstrb_o = 4'b1111;
			end
			default: begin
				wdata_o = '0;
				wstrb_o = '0;
			end
		endcase
	end

endmodule

// ==== hw/ex_mem_reg.sv ====
// One-entry EX/MEM register with a valid/ready output side.
// data_mem_i must hold the read word in the same cycle as load_fire_i.
// in_ready_o is high when empty or when the held word drains this cycle.
`timescale 1ns/1ps

module ex_mem_reg
	import rv_isa_pkg::*;
	import ex_cfg_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset_i,
	input  logic                   load_fire_i,
	input  load_e                  load_i,
	input  logic [XLEN-1:0]        alu_i,
	input  logic [XLEN-1:0]        data_mem_i,
	input  logic [REG_ADDR_W-1:0]  rd_i,
	input  logic                   we_i,
	input  logic                   out_ready_i,
	output logic                   in_ready_o,
	output logic                   out_valid_o,
	output logic [REG_ADDR_W-1:0]  addr_reg_wr_o,
	output logic [XLEN-1:0]        data_reg_wr_o,
	output logic                   reg_wr_en_o
);

	logic [7:0]      byte_sel;
	logic [15:0]     half_sel;
	logic [XLEN-1:0] wb_data;

	// lane select from the low address bits
	assign byte_sel = data_mem_i[{alu_i[1:0], 3'b000} +: 8];
	assign half_sel = data_mem_i[{alu_i[1], 4'b0000} +: 16];

	always_comb begin
		case (load_i)
			LD_LB:   wb_data = {{(XLEN-8){byte_sel[7]}}, byte_sel};
			LD_LH:   wb_data = {{(XLEN-16){half_sel[15]}}, half_sel};
			LD_LW:   wb_data = data_mem_i;
			LD_LBU:  wb_data = {{(XLEN-8){1'b0}}, byte_sel};
			LD_LHU:  wb_data = {{(XLEN-16){1'b0}}, half_sel};
			default: wb_data = alu_i;
		endcase
	end

	assign in_ready_o = !out_valid_o || out_ready_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			out_valid_o <= 1'b0;
			reg_wr_en_o <= 1'b0;
		end else if (load_fire_i) begin
			out_valid_o <= 1'b1;
			reg_wr_en_o <= we_i;
		end else if (out_ready_i) begin
			out_valid_o <= 1'b0;
			reg_wr_en_o <= 1'b0;
		end
	end

	// payload only
	always_ff @(posedge clk) begin
		if (load_fire_i) begin
			addr_reg_wr_o <= rd_i;
			data_reg_wr_o <= wb_data;
		end
	end

	// a held word must not change until downstream takes it
	a_hold_stable: assert property (@(posedge clk) disable iff (reset_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(data_reg_wr_o)
			&& $stable(addr_reg_wr_o) && $stable(reg_wr_en_o));

endmodule

// ==== hw/ex_stage.sv ====
// RV32I execute stage with valid/ready on both sides.
// Branch and memory request outputs are combinational and valid only on input fire.
// Register write leaves one cycle after fire; data memory is assumed zero latency.
`timescale 1ns/1ps

module ex_stage
	import rv_isa_pkg::*;
	import ex_cfg_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset_i,

	input  logic                   in_valid_i,
	output logic                   in_ready_o,
	input  logic                   out_ready_i,
	output logic                   out_valid_o,

	input  alu_op_e                alu_op_i,
	input  logic [XLEN-1:0]        alu_a_i,
	input  logic [XLEN-1:0]        alu_b_i,

	input  branch_e                branch_i,
	input  logic [XLEN-1:0]        data_rs1_i,
	input  logic [XLEN-1:0]        data_rs2_i,
	input  logic [XLEN-1:0]        jmp_a_i,
	input  logic [XLEN-1:0]        jmp_b_i,

	input  load_e                  load_i,
	input  store_e                 store_i,
	input  logic [XLEN-1:0]        data_mem_i,

	input  logic [REG_ADDR_W-1:0]  addr_reg_wr_i,
	input  logic                   reg_wr_en_i,

	output logic [XLEN-1:0]        alu_result_o,
	output logic                   jmp_en_o,
	output logic [XLEN-1:0]        jmp_to_o,
	output logic                   mem_req_o,
	output logic                   mem_we_o,
	output logic [XLEN-1:0]        mem_addr_o,
	output logic [XLEN-1:0]        mem_wdata_o,
	output logic [STRB_W-1:0]      mem_wstrb_o,
	output logic [REG_ADDR_W-1:0]  addr_reg_wr_o,
	output logic [XLEN-1:0]        data_reg_wr_o,
	output logic                   reg_wr_en_o
);

	logic in_fire;
	logic br_take;
	logic st_req;

	assign in_fire = in_valid_i && in_ready_o;

	ex_alu u_alu (
		.op_i     (alu_op_i),
		.a_i      (alu_a_i),
		.b_i      (alu_b_i),
		.result_o (alu_result_o)
	);

	ex_branch_unit u_branch (
		.branch_i (branch_i),
		.rs1_i    (data_rs1_i),
		.rs2_i    (data_rs2_i),
		.jmp_a_i  (jmp_a_i),
		.jmp_b_i  (jmp_b_i),
		.take_o   (br_take),
		.target_o (jmp_to_o)
	);

	// address is the alu sum for loads and stores
	assign mem_addr_o = alu_result_o;

	ex_store_unit u_store (
		.load_i  (load_i),
		.store_i (store_i),
		.addr_i  (alu_result_o),
		.rs2_i   (data_rs2_i),
		.req_o   (st_req),
		.we_o    (mem_we_o),
		.wdata_o (mem_wdata_o),
		.wstrb_o (mem_wstrb_o)
	);

	assign jmp_en_o  = in_fire && br_take;
	assign mem_req_o = in_fire && st_req;

	ex_mem_reg u_mem_reg (
		.clk           (clk),
		.reset_i       (reset_i),
		.load_fire_i   (in_fire),
		.load_i        (load_i),
		.alu_i         (alu_result_o),
		.data_mem_i    (data_mem_i),
		.rd_i          (addr_reg_wr_i),
		.we_i          (reg_wr_en_i),
		.out_ready_i   (out_ready_i),
		.in_ready_o    (in_ready_o),
		.out_valid_o   (out_valid_o),
		.addr_reg_wr_o (addr_reg_wr_o),
		.data_reg_wr_o (data_reg_wr_o),
		.reg_wr_en_o   (reg_wr_en_o)
	);

	// only legal alu opcodes may enter
	a_alu_op_legal: assert property (@(posedge clk) disable iff (reset_i)
		in_fire |-> alu_op_i inside {[ALU_ADD:ALU_PASS_B]});

	// stores are never split, so they must be naturally aligned
	a_store_aligned: assert property (@(posedge clk) disable iff (reset_i)
		in_fire |-> !((store_i == ST_SH) && alu_result_o[0])
			&& !((store_i == ST_SW) && (alu_result_o[1:0] != 2'b00)));

endmodule

// ==== tests/ex_stage_tb.sv ====
// Self-checking testbench for ex_stage driven by tests/ex_stage_stim.txt.
// Run from the project root so the vector file is found.
// Data memory is ideal: each vector carries the read word for its load.
`timescale 1ns/1ps

module ex_stage_tb
	import rv_isa_pkg::*;
	import ex_cfg_pkg::*;
();

	localparam int RESET_CYCLES  = 16;
	localparam int WORDS_PER_VEC = 12;
	localparam int MAX_VECS      = 64;

	logic                  clk;
	logic                  reset_i;
	logic                  in_valid_i;
	logic                  in_ready_o;
	logic                  out_ready_i;
	logic                  out_valid_o;
	alu_op_e               alu_op_i;
	logic [XLEN-1:0]       alu_a_i;
	logic [XLEN-1:0]       alu_b_i;
	branch_e               branch_i;
	logic [XLEN-1:0]       data_rs1_i;
	logic [XLEN-1:0]       data_rs2_i;
	logic [XLEN-1:0]       jmp_a_i;
	logic [XLEN-1:0]       jmp_b_i;
	load_e                 load_i;
	store_e                store_i;
	logic [XLEN-1:0]       data_mem_i;
	logic [REG_ADDR_W-1:0] addr_reg_wr_i;
	logic                  reg_wr_en_i;
	logic [XLEN-1:0]       alu_result_o;
	logic                  jmp_en_o;
	logic [XLEN-1:0]       jmp_to_o;
	logic                  mem_req_o;
	logic                  mem_we_o;
	logic [XLEN-1:0]       mem_addr_o;
	logic [XLEN-1:0]       mem_wdata_o;
	logic [STRB_W-1:0]     mem_wstrb_o;
	logic [REG_ADDR_W-1:0] addr_reg_wr_o;
	logic [XLEN-1:0]       data_reg_wr_o;
	logic                  reg_wr_en_o;

	logic [31:0]                stim_mem [0:WORDS_PER_VEC*MAX_VECS-1];
	// {wr_en, rd, data} per accepted instruction in order of acceptance
	logic [XLEN+REG_ADDR_W:0]   exp_q [$];
	logic [31:0]                lcg_state;
	logic                       fired;
	int                         num_vecs;
	int                         vec_idx;
	int                         received;
	int                         cycle_limit;
	int                         cycle_count;
	int                         value_errs;
	int                         other_errs;

	ex_stage u_ex_stage (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic print_error_counts();
		$display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
	endtask

	task automatic drive_vector(input int idx);
		int          base;
		logic [31:0] ctrl;
		base = idx * WORDS_PER_VEC;
		ctrl = stim_mem[base];
		alu_op_i      <= alu_op_e'(ctrl[27:24]);
		branch_i      <= branch_e'(ctrl[22:20]);
		load_i        <= load_e'(ctrl[18:16]);
		store_i       <= store_e'(ctrl[13:12]);
		reg_wr_en_i   <= ctrl[8];
		addr_reg_wr_i <= ctrl[REG_ADDR_W-1:0];
		alu_a_i       <= stim_mem[base+1];
		alu_b_i       <= stim_mem[base+2];
		data_rs1_i    <= stim_mem[base+3];
		data_rs2_i    <= stim_mem[base+4];
		jmp_a_i       <= stim_mem[base+5];
		jmp_b_i       <= stim_mem[base+6];
		data_mem_i    <= stim_mem[base+7];
	endtask

	// same-cycle outputs of an accepted instruction
	task automatic check_fire(input int idx);
		int          base;
		logic [31:0] ctrl;
		logic [31:0] exp_ctrl;
		logic        mem_access;
		base       = idx * WORDS_PER_VEC;
		ctrl       = stim_mem[base];
		exp_ctrl   = stim_mem[base+11];
		mem_access = (ctrl[18:16] != 3'd0) || (ctrl[13:12] != 2'd0);
		check_value("jmp_en_o", 32'(jmp_en_o), 32'(exp_ctrl[20]));
		check_value("jmp_to_o", jmp_to_o, stim_mem[base+8]);
		check_value("mem_req_o", 32'(mem_req_o), 32'(mem_access));
		check_value("mem_we_o", 32'(mem_we_o), 32'(exp_ctrl[16]));
		check_value("mem_wdata_o", mem_wdata_o, stim_mem[base+9]);
		check_value("mem_wstrb_o", 32'(mem_wstrb_o), 32'(exp_ctrl[15:12]));
		// register data is the alu result unless a load replaces it
		if (ctrl[18:16] == 3'd0) begin
			check_value("alu_result_o", alu_result_o, stim_mem[base+10]);
		end
		if (mem_access) begin
			check_value("mem_addr_o", mem_addr_o, stim_mem[base+1] + stim_mem[base+2]);
		end
		exp_q.push_back({exp_ctrl[8], exp_ctrl[REG_ADDR_W-1:0], stim_mem[base+10]});
	endtask

	task automatic check_output();
		logic [XLEN+REG_ADDR_W:0] exp_wr;
		if (exp_q.size() == 0) begin
			$display("register write at %0t has no pending instruction", $time);
			other_errs++;
		end else begin
			exp_wr = exp_q.pop_front();
			check_value("reg_wr_en_o", 32'(reg_wr_en_o), 32'(exp_wr[XLEN+REG_ADDR_W]));
			check_value("addr_reg_wr_o", 32'(addr_reg_wr_o), 32'(exp_wr[XLEN +: REG_ADDR_W]));
			check_value("data_reg_wr_o", data_reg_wr_o, exp_wr[XLEN-1:0]);
		end
		received++;
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles, %0d of %0d register writes seen",
				cycle_count, received, num_vecs);
			print_error_counts();
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		logic [31:0] rnd;
		reset_i       = 1'b1;
		in_valid_i    = 1'b0;
		out_ready_i   = 1'b0;
		alu_op_i      = ALU_ADD;
		alu_a_i       = '0;
		alu_b_i       = '0;
		branch_i      = BR_NONE;
		data_rs1_i    = '0;
		data_rs2_i    = '0;
		jmp_a_i       = '0;
		jmp_b_i       = '0;
		load_i        = LD_NONE;
		store_i       = ST_NONE;
		data_mem_i    = '0;
		addr_reg_wr_i = '0;
		reg_wr_en_i   = 1'b0;
		lcg_state     = 32'd89872;
		value_errs    = 0;
		other_errs    = 0;
		cycle_count   = 0;
		received      = 0;
		vec_idx       = 0;
		fired         = 1'b0;

		// end of vectors shows as a fill word with f in the top nibble
		for (int i = 0; i < WORDS_PER_VEC * MAX_VECS; i++) begin
			stim_mem[i] = 32'hf000_0000 | 32'(i);
		end
		$readmemh("tests/ex_stage_stim.txt", stim_mem);
		num_vecs = 0;
		while (num_vecs < MAX_VECS && stim_mem[num_vecs*WORDS_PER_VEC][31:28] != 4'hf) begin
			num_vecs++;
		end
		if (num_vecs == 0) begin
			$display("no vectors were read from the stimulus file");
			other_errs++;
		end
		cycle_limit = RESET_CYCLES + 8 * num_vecs + 100;

		repeat (RESET_CYCLES) @(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		check_value("out_valid_o", 32'(out_valid_o), 32'd0);
		check_value("reg_wr_en_o", 32'(reg_wr_en_o), 32'd0);
		check_value("jmp_en_o", 32'(jmp_en_o), 32'd0);
		check_value("mem_req_o", 32'(mem_req_o), 32'd0);

		while (received < num_vecs) begin
			@(posedge clk);
			// a presented instruction stays put until it is taken
			if (!in_valid_i || fired) begin
				rnd = next_rand();
				if (vec_idx < num_vecs && rnd[31:30] != 2'b00) begin
					drive_vector(vec_idx);
					in_valid_i <= 1'b1;
				end else begin
					in_valid_i <= 1'b0;
				end
			end
			rnd = next_rand();
			out_ready_i <= rnd[31:30] != 2'b00;
			@(negedge clk);
			fired = in_valid_i && in_ready_o;
			if (out_valid_o && out_ready_i) begin
				check_output();
			end
			if (out_valid_o && !out_ready_i) begin
				check_value("in_ready_o", 32'(in_ready_o), 32'd0);
			end
			if (fired) begin
				check_fire(vec_idx);
				vec_idx++;
			end else begin
				check_value("jmp_en_o", 32'(jmp_en_o), 32'd0);
				check_value("mem_req_o", 32'(mem_req_o), 32'd0);
			end
		end

		@(posedge clk);
		in_valid_i  <= 1'b0;
		out_ready_i <= 1'b1;
		@(negedge clk);
		check_value("out_valid_o", 32'(out_valid_o), 32'd0);
		if (exp_q.size() != 0) begin
			$display("%0d register writes never left the stage", exp_q.size());
			other_errs++;
		end

		print_error_counts();
		if (value_errs == 0 && other_errs == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== tests/ex_stage_stim.txt ====
// ctrl(op br ld st we rd) alu_a alu_b rs1 rs2 jmp_a jmp_b data_mem, then expected
// jmp_to mem_wdata reg_data and expected ctrl(jmp_en mem_we wstrb wr_en rd)
0000101 00001234 00000f0f 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002143 000101
1000103 00000005 00000007 00000000 00000000 00000000 00000000 00000000 00000000 00000000 fffffffe 000103
2000104 00000001 0000002f 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00008000 000104
3000105 ffffffff 00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000001 000105
4000106 ffffffff 00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 000106
5000107 f0f0f0f0 ff00ff00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0ff00ff0 000107
6000108 80000000 00000004 00000000 00000000 00000000 00000000 00000000 00000000 00000000 08000000 000108
7000109 80000000 00000024 00000000 00000000 00000000 00000000 00000000 00000000 00000000 f8000000 000109
800010a 12340000 00005678 00000000 00000000 00000000 00000000 00000000 00000000 00000000 12345678 00010a
900010b f0f0f0f0 ff00ff00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 f000f000 00010b
a00010c deadbeef abcde000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 abcde000 00010c
0100101 00001000 00000004 00000000 00000000 00001000 00000011 00000000 00001010 00000000 00001004 100101
0200000 00000000 00000000 00000010 00000010 00001000 00000011 00000000 00001010 00000000 00000000 100000
0200000 00000000 00000000 00000010 00000011 00001000 00000011 00000000 00001010 00000000 00000000 000000
0300000 00000000 00000000 00000010 00000011 00001000 00000011 00000000 00001010 00000000 00000000 100000
0400000 00000000 00000000 ffffffff 00000001 00002000 fffffff8 00000000 00001ff8 00000000 00000000 100000
0500000 00000000 00000000 ffffffff 00000001 00001000 00000011 00000000 00001010 00000000 00000000 000000
0600000 00000000 00000000 ffffffff 00000001 00001000 00000011 00000000 00001010 00000000 00000000 000000
0700000 00000000 00000000 ffffffff 00000001 00001000 00000011 00000000 00001010 00000000 00000000 100000
0001000 00000100 00000000 00000000 a1b2c3d4 00000000 00000000 00000000 00000000 d4d4d4d4 00000100 011000
0001000 00000100 00000001 00000000 a1b2c3d4 00000000 00000000 00000000 00000000 d4d4d4d4 00000101 012000
0001000 00000100 00000002 00000000 a1b2c3d4 00000000 00000000 00000000 00000000 d4d4d4d4 00000102 014000
0001000 00000100 00000003 00000000 a1b2c3d4 00000000 00000000 00000000 00000000 d4d4d4d4 00000103 018000
0002000 00000200 00000000 00000000 a1b2c3d4 00000000 00000000 00000000 00000000 c3d4c3d4 00000200 013000
0002000 00000200 00000002 00000000 a1b2c3d4 00000000 00000000 00000000 00000000 c3d4c3d4 00000202 01c000
0003000 000002fc 00000004 00000000 a1b2c3d4 00000000 00000000 00000000 00000000 a1b2c3d4 00000300 01f000
0010110 00000400 00000000 00000000 00000000 00000000 00000000 80ff7f01 00000000 00000000 00000001 000110
0010111 00000400 00000001 00000000 00000000 00000000 00000000 80ff7f01 00000000 00000000 0000007f 000111
0010112 00000400 00000002 00000000 00000000 00000000 00000000 80ff7f01 00000000 00000000 ffffffff 000112
0010113 00000400 00000003 00000000 00000000 00000000 00000000 80ff7f01 00000000 00000000 ffffff80 000113
0040114 00000400 00000000 00000000 00000000 00000000 00000000 80ff7f01 00000000 00000000 00000001 000114
0040115 00000400 00000001 00000000 00000000 00000000 00000000 80ff7f01 00000000 00000000 0000007f 000115
0040116 00000400 00000002 00000000 00000000 00000000 00000000 80ff7f01 00000000 00000000 000000ff 000116
0040117 00000400 00000003 00000000 00000000 00000000 00000000 80ff7f01 00000000 00000000 00000080 000117
0020118 00000400 00000000 00000000 00000000 00000000 00000000 80ff7f01 00000000 00000000 00007f01 000118
0020119 00000400 00000002 00000000 00000000 00000000 00000000 80ff7f01 00000000 00000000 ffff80ff 000119
005011a 00000400 00000000 00000000 00000000 00000000 00000000 80ff7f01 00000000 00000000 00007f01 00011a
005011b 00000400 00000002 00000000 00000000 00000000 00000000 80ff7f01 00000000 00000000 000080ff 00011b
003011c 00000400 00000000 00000000 00000000 00000000 00000000 80ff7f01 00000000 00000000 80ff7f01 00011c

// ==== filelist.f ====
hw/rv_isa_pkg.sv
hw/ex_cfg_pkg.sv
hw/ex_alu.sv
hw/ex_branch_unit.sv
hw/ex_store_unit.sv
hw/ex_mem_reg.sv
hw/ex_stage.sv
tests/ex_stage_tb.sv

// ==== Makefile ====
# Verilator build and run for the execute stage testbench

SIM = obj_dir/Vex_stage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module ex_stage_tb -f filelist.f -Mdir obj_dir

run: compile
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "simulation FAILED"; exit 1; \
	elif grep -q "Test completed successfully" sim.log; then \
		echo "simulation PASSED"; \
	else \
		echo "simulation gave no result, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
